// ==== rv_core_pkg.sv ====
// Shared types for the RV32I pipelined core
// Word and register types, control encodings, stage records and AHB codes

`default_nettype none

package rv_core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;

	// addi x0, x0, 0
	localparam word_t NOP_INSTR = 32'h0000_0013;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {SRC_A_RS1, SRC_A_PC, SRC_A_ZERO} src_a_e;
	typedef enum logic [1:0] {SRC_B_RS2, SRC_B_IMM, SRC_B_FOUR} src_b_e;

	typedef enum logic [3:0] {
		MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
	} mem_op_e;

	typedef enum logic [3:0] {
		BR_NEVER, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
	} branch_e;

	// ============================================================
	// AHB-lite codes
	// ============================================================
	typedef enum logic [1:0] {HTRANS_IDLE = 2'b00, HTRANS_NONSEQ = 2'b10} htrans_e;
	typedef enum logic [2:0] {HSIZE_BYTE = 3'b000, HSIZE_HALF = 3'b001, HSIZE_WORD = 3'b010} hsize_e;

	// ============================================================
	// Stage records
	// ============================================================
	typedef struct packed {
		logic     valid;
		word_t    pc;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		word_t    imm;
		src_a_e   src_a;
		src_b_e   src_b;
		alu_op_e  alu_op;
		mem_op_e  mem_op;
		branch_e  branch;
	} dx_ctrl_t;

	typedef struct packed {
		logic   valid;
		word_t  addr;
		logic   write;
		hsize_e size;
	} mem_req_t;

	typedef struct packed {
		reg_idx_t rd;
		word_t    result;
		mem_op_e  mem_op;
		word_t    store_data;
	} xm_t;

	// rd of zero means no write
	typedef struct packed {
		reg_idx_t rd;
		word_t    value;
	} wb_t;

	typedef struct packed {
		logic  valid;
		word_t target;
	} redirect_t;

	function automatic logic is_load(mem_op_e op);
		return op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
	endfunction

endpackage

`default_nettype wire

// ==== rv_bus_ctrl.sv ====
// AHB-lite address phase owner
// Arbitrates load/store, redirect and sequential fetch, and tracks
// what the outstanding data phase carries

`default_nettype none

module rv_bus_ctrl (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   hready_i,
	input  rv_core_pkg::word_t     hrdata_i,
	input  rv_core_pkg::mem_req_t  mem_req_i,
	input  rv_core_pkg::redirect_t redirect_i,
	input  rv_core_pkg::word_t     fetch_addr_i,
	input  logic                   hold_i,
	output rv_core_pkg::word_t     haddr_o,
	output rv_core_pkg::htrans_e   htrans_o,
	output logic                   hwrite_o,
	output rv_core_pkg::hsize_e    hsize_o,
	output logic                   stall_o,
	output logic                   fetch_issue_o,
	output rv_core_pkg::word_t     instr_o,
	output logic                   instr_valid_o
);
	import rv_core_pkg::*;

	typedef enum logic [1:0] {PH_NONE, PH_FETCH, PH_DISCARD, PH_DATA} phase_e;

	phase_e phase_q;
	phase_e phase_d;
	phase_e data_phase;
	logic   started_q;
	logic   fetch_now;

	assign stall_o = !hready_i;
	assign instr_o = hrdata_i;

	// A fetch overlapping a redirect is dropped before decode
	assign data_phase = (phase_q == PH_FETCH && redirect_i.valid) ? PH_DISCARD : phase_q;
	assign instr_valid_o = data_phase == PH_FETCH;

	// Load/store beats redirect, which beats sequential fetch
	always_comb begin
		htrans_o  = HTRANS_IDLE;
		haddr_o   = '0;
		hwrite_o  = 1'b0;
		hsize_o   = HSIZE_WORD;
		phase_d   = PH_NONE;
		fetch_now = 1'b0;
		if (mem_req_i.valid) begin
			htrans_o = HTRANS_NONSEQ;
			haddr_o  = mem_req_i.addr;
			hwrite_o = mem_req_i.write;
			hsize_o  = mem_req_i.size;
			phase_d  = PH_DATA;
		end else if (started_q && redirect_i.valid) begin
			htrans_o  = HTRANS_NONSEQ;
			haddr_o   = redirect_i.target;
			phase_d   = PH_FETCH;
			fetch_now = 1'b1;
		end else if (started_q && !hold_i) begin
			htrans_o  = HTRANS_NONSEQ;
			haddr_o   = fetch_addr_i;
			phase_d   = PH_FETCH;
			fetch_now = 1'b1;
		end
	end

	assign fetch_issue_o = fetch_now && hready_i;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase_q   <= PH_NONE;
			started_q <= 1'b0;
		end else if (hready_i) begin
			phase_q   <= phase_d;
			started_q <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== rv_pc_counter.sv ====
// Fetch address counter
// Also keeps the PC of the word now in its fetch data phase

`default_nettype none

module rv_pc_counter #(
	parameter rv_core_pkg::word_t RESET_VECTOR = 32'h0000_0000
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   stall_i,
	input  logic                   hold_i,
	input  logic                   fetch_issue_i,
	input  rv_core_pkg::redirect_t redirect_i,
	output rv_core_pkg::word_t     fetch_addr_o,
	output rv_core_pkg::word_t     fetch_pc_o
);
	import rv_core_pkg::*;

	word_t fetch_addr_q;
	word_t fetch_pc_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr_q <= RESET_VECTOR;
			fetch_pc_q   <= RESET_VECTOR;
		end else if (!stall_i && !hold_i && fetch_issue_i) begin
			// Target goes out directly, so continue from the word after it
			if (redirect_i.valid) begin
				fetch_addr_q <= redirect_i.target + 32'd4;
				fetch_pc_q   <= redirect_i.target;
			end else begin
				fetch_addr_q <= fetch_addr_q + 32'd4;
				fetch_pc_q   <= fetch_addr_q;
			end
		end
	end

	assign fetch_addr_o = fetch_addr_q;
	assign fetch_pc_o   = fetch_pc_q;

endmodule

`default_nettype wire

// ==== rv_decode.sv ====
// Instruction decode into the decode-to-execute record
// Invalid or squashed words decode as a bubble

`default_nettype none

module rv_decode (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   stall_i,
	input  logic                   hold_i,
	input  rv_core_pkg::redirect_t redirect_i,
	input  rv_core_pkg::word_t     instr_i,
	input  logic                   instr_valid_i,
	input  rv_core_pkg::word_t     pc_i,
	output rv_core_pkg::reg_idx_t  rs1_o,
	output rv_core_pkg::reg_idx_t  rs2_o,
	output rv_core_pkg::dx_ctrl_t  dx_o
);
	import rv_core_pkg::*;

	logic     live;
	word_t    instr;
	logic [2:0] f3;
	word_t    imm_i;
	word_t    imm_s;
	word_t    imm_b;
	word_t    imm_u;
	word_t    imm_j;
	dx_ctrl_t dx_next;
	dx_ctrl_t dx_q;

	function automatic alu_op_e alu_from_f3(logic [2:0] fn, logic alt);
		alu_op_e op;
		case (fn)
			3'b000:  op = alt ? ALU_SUB : ALU_ADD;
			3'b001:  op = ALU_SLL;
			3'b010:  op = ALU_SLT;
			3'b011:  op = ALU_SLTU;
			3'b100:  op = ALU_XOR;
			3'b101:  op = alt ? ALU_SRA : ALU_SRL;
			3'b110:  op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	assign live  = instr_valid_i && !redirect_i.valid;
	assign instr = live ? instr_i : NOP_INSTR;
	assign f3    = instr[14:12];
	assign rs1_o = instr[19:15];
	assign rs2_o = instr[24:20];

	assign imm_i = {{21{instr[31]}}, instr[30:20]};
	assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'h000};
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		dx_next        = '0;
		dx_next.valid  = live;
		dx_next.pc     = pc_i;
		dx_next.rs1    = instr[19:15];
		dx_next.rs2    = instr[24:20];
		dx_next.rd     = instr[11:7];
		dx_next.imm    = imm_i;
		dx_next.src_a  = SRC_A_RS1;
		dx_next.src_b  = SRC_B_RS2;
		dx_next.alu_op = ALU_ADD;
		dx_next.mem_op = MEM_NONE;
		dx_next.branch = BR_NEVER;
		case (instr[6:0])
			7'b0110111: begin
				dx_next.imm    = imm_u;
				dx_next.src_a  = SRC_A_ZERO;
				dx_next.src_b  = SRC_B_IMM;
				dx_next.alu_op = ALU_PASS_B;
			end
			7'b0010111: begin
				dx_next.imm   = imm_u;
				dx_next.src_a = SRC_A_PC;
				dx_next.src_b = SRC_B_IMM;
			end
			// Jumps link PC + 4 through the ALU
			7'b1101111: begin
				dx_next.imm    = imm_j;
				dx_next.src_a  = SRC_A_PC;
				dx_next.src_b  = SRC_B_FOUR;
				dx_next.branch = BR_JAL;
			end
			7'b1100111: begin
				dx_next.src_a  = SRC_A_PC;
				dx_next.src_b  = SRC_B_FOUR;
				dx_next.branch = BR_JALR;
			end
			7'b1100011: begin
				dx_next.imm = imm_b;
				dx_next.rd  = '0;
				case (f3)
					3'b000:  dx_next.branch = BR_EQ;
					3'b001:  dx_next.branch = BR_NE;
					3'b100:  dx_next.branch = BR_LT;
					3'b101:  dx_next.branch = BR_GE;
					3'b110:  dx_next.branch = BR_LTU;
					3'b111:  dx_next.branch = BR_GEU;
					default: dx_next.branch = BR_NEVER;
				endcase
			end
			7'b0000011: begin
				dx_next.src_b = SRC_B_IMM;
				case (f3)
					3'b000:  dx_next.mem_op = MEM_LB;
					3'b001:  dx_next.mem_op = MEM_LH;
					3'b010:  dx_next.mem_op = MEM_LW;
					3'b100:  dx_next.mem_op = MEM_LBU;
					3'b101:  dx_next.mem_op = MEM_LHU;
					default: dx_next.rd = '0;
				endcase
			end
			7'b0100011: begin
				dx_next.imm   = imm_s;
				dx_next.src_b = SRC_B_IMM;
				dx_next.rd    = '0;
				case (f3)
					3'b000:  dx_next.mem_op = MEM_SB;
					3'b001:  dx_next.mem_op = MEM_SH;
					3'b010:  dx_next.mem_op = MEM_SW;
					default: dx_next.mem_op = MEM_NONE;
				endcase
			end
			7'b0010011: begin
				dx_next.src_b  = SRC_B_IMM;
				dx_next.alu_op = alu_from_f3(f3, f3 == 3'b101 && instr[30]);
			end
			7'b0110011: dx_next.alu_op = alu_from_f3(f3, instr[30]);
			// FENCE, SYSTEM and illegal words retire as no-ops
			default: dx_next.rd = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dx_q <= '0;
		end else if (!stall_i && !hold_i) begin
			dx_q <= dx_next;
		end
	end

	assign dx_o = dx_q;

endmodule

`default_nettype wire

// ==== rv_regfile.sv ====
// Integer register file, x0 hardwired to zero
// Two registered read ports with write-through from writeback

`default_nettype none

module rv_regfile (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  stall_i,
	input  logic                  hold_i,
	input  rv_core_pkg::reg_idx_t rs1_i,
	input  rv_core_pkg::reg_idx_t rs2_i,
	input  rv_core_pkg::wb_t      wb_i,
	output rv_core_pkg::word_t    rdata1_o,
	output rv_core_pkg::word_t    rdata2_o
);
	import rv_core_pkg::*;

	word_t    regs [1:31];
	reg_idx_t ra1_q;
	reg_idx_t ra2_q;
	reg_idx_t ra1;
	reg_idx_t ra2;
	word_t    rd1;
	word_t    rd2;
	word_t    rdata1_q;
	word_t    rdata2_q;

	// Held indices are re-read so a writeback during hold is not missed
	assign ra1 = (stall_i || hold_i) ? ra1_q : rs1_i;
	assign ra2 = (stall_i || hold_i) ? ra2_q : rs2_i;

	assign rd1 = (ra1 == '0) ? '0 : (ra1 == wb_i.rd) ? wb_i.value : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : (ra2 == wb_i.rd) ? wb_i.value : regs[ra2];

	always_ff @(posedge clk) begin
		if (wb_i.rd != '0) begin
			regs[wb_i.rd] <= wb_i.value;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ra1_q    <= '0;
			ra2_q    <= '0;
			rdata1_q <= '0;
			rdata2_q <= '0;
		end else if (!stall_i) begin
			ra1_q    <= ra1;
			ra2_q    <= ra2;
			rdata1_q <= rd1;
			rdata2_q <= rd2;
		end
	end

	assign rdata1_o = rdata1_q;
	assign rdata2_o = rdata2_q;

endmodule

`default_nettype wire

// ==== rv_execute.sv ====
// Execute stage
// Forwarding, ALU, branch resolution, load/store request and the
// execute-to-memory register

`default_nettype none

module rv_execute (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   stall_i,
	input  rv_core_pkg::dx_ctrl_t  dx_i,
	input  rv_core_pkg::word_t     rdata1_i,
	input  rv_core_pkg::word_t     rdata2_i,
	input  rv_core_pkg::wb_t       wb_i,
	output rv_core_pkg::mem_req_t  mem_req_o,
	output rv_core_pkg::redirect_t redirect_o,
	output logic                   hold_o,
	output rv_core_pkg::xm_t       xm_o
);
	import rv_core_pkg::*;

	xm_t   xm_q;
	word_t rs1_val;
	word_t rs2_val;
	word_t op_a;
	word_t op_b;
	word_t alu_res;
	logic  taken;

	// Newest producer wins
	function automatic word_t fwd(reg_idx_t idx, word_t rf, xm_t xm, wb_t wb);
		if (idx == '0) return '0;
		if (idx == xm.rd) return xm.result;
		if (idx == wb.rd) return wb.value;
		return rf;
	endfunction

	assign rs1_val = fwd(dx_i.rs1, rdata1_i, xm_q, wb_i);
	assign rs2_val = fwd(dx_i.rs2, rdata2_i, xm_q, wb_i);

	// Load result not ready until writeback
	assign hold_o = dx_i.valid && is_load(xm_q.mem_op) && xm_q.rd != '0 &&
		(xm_q.rd == dx_i.rs1 || xm_q.rd == dx_i.rs2);

	always_comb begin
		case (dx_i.src_a)
			SRC_A_PC:   op_a = dx_i.pc;
			SRC_A_ZERO: op_a = '0;
			default:    op_a = rs1_val;
		endcase
		case (dx_i.src_b)
			SRC_B_IMM:  op_b = dx_i.imm;
			SRC_B_FOUR: op_b = 32'd4;
			default:    op_b = rs2_val;
		endcase
		case (dx_i.alu_op)
			ALU_SUB:    alu_res = op_a - op_b;
			ALU_SLL:    alu_res = op_a << op_b[4:0];
			ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU:   alu_res = {31'b0, op_a < op_b};
			ALU_XOR:    alu_res = op_a ^ op_b;
			ALU_SRL:    alu_res = op_a >> op_b[4:0];
			ALU_SRA:    alu_res = word_t'($signed(op_a) >>> op_b[4:0]);
			ALU_OR:     alu_res = op_a | op_b;
			ALU_AND:    alu_res = op_a & op_b;
			ALU_PASS_B: alu_res = op_b;
			default:    alu_res = op_a + op_b;
		endcase
		case (dx_i.branch)
			BR_EQ:           taken = rs1_val == rs2_val;
			BR_NE:           taken = rs1_val != rs2_val;
			BR_LT:           taken = $signed(rs1_val) < $signed(rs2_val);
			BR_GE:           taken = $signed(rs1_val) >= $signed(rs2_val);
			BR_LTU:          taken = rs1_val < rs2_val;
			BR_GEU:          taken = rs1_val >= rs2_val;
			BR_JAL, BR_JALR: taken = 1'b1;
			default:         taken = 1'b0;
		endcase
	end

	assign redirect_o.valid  = dx_i.valid && taken && !hold_o;
	assign redirect_o.target = (dx_i.branch == BR_JALR) ?
		((rs1_val + dx_i.imm) & ~32'd1) : (dx_i.pc + dx_i.imm);

	assign mem_req_o.valid = dx_i.valid && dx_i.mem_op != MEM_NONE && !hold_o;
	assign mem_req_o.addr  = alu_res;
	assign mem_req_o.write = dx_i.mem_op inside {MEM_SB, MEM_SH, MEM_SW};
	assign mem_req_o.size  = (dx_i.mem_op inside {MEM_LB, MEM_LBU, MEM_SB}) ? HSIZE_BYTE :
		(dx_i.mem_op inside {MEM_LH, MEM_LHU, MEM_SH}) ? HSIZE_HALF : HSIZE_WORD;

	// Bubble into M on hold or empty slot
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			xm_q <= '0;
		end else if (!stall_i) begin
			if (dx_i.valid && !hold_o) begin
				xm_q.rd         <= dx_i.rd;
				xm_q.result     <= alu_res;
				xm_q.mem_op     <= dx_i.mem_op;
				xm_q.store_data <= rs2_val;
			end else begin
				xm_q <= '0;
			end
		end
	end

	assign xm_o = xm_q;

endmodule

`default_nettype wire

// ==== rv_mem_stage.sv ====
// Memory stage
// Store lane replication, load alignment and extension, writeback register

`default_nettype none

module rv_mem_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               stall_i,
	input  rv_core_pkg::xm_t   xm_i,
	input  rv_core_pkg::word_t hrdata_i,
	output rv_core_pkg::word_t hwdata_o,
	output rv_core_pkg::wb_t   wb_o
);
	import rv_core_pkg::*;

	word_t shifted;
	word_t load_val;
	wb_t   wb_q;

	always_comb begin
		case (xm_i.mem_op)
			MEM_SB:  hwdata_o = {4{xm_i.store_data[7:0]}};
			MEM_SH:  hwdata_o = {2{xm_i.store_data[15:0]}};
			default: hwdata_o = xm_i.store_data;
		endcase
		// Bring the addressed lane down to bit 0
		shifted = hrdata_i >> {xm_i.result[1:0], 3'b000};
		case (xm_i.mem_op)
			MEM_LB:  load_val = {{24{shifted[7]}}, shifted[7:0]};
			MEM_LBU: load_val = {24'h0, shifted[7:0]};
			MEM_LH:  load_val = {{16{shifted[15]}}, shifted[15:0]};
			MEM_LHU: load_val = {16'h0, shifted[15:0]};
			default: load_val = shifted;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_q <= '0;
		end else if (!stall_i) begin
			wb_q.rd    <= xm_i.rd;
			wb_q.value <= is_load(xm_i.mem_op) ? load_val : xm_i.result;
		end
	end

	assign wb_o = wb_q;

endmodule

`default_nettype wire

// ==== rv_core.sv ====
// RV32I integer core, four-stage pipeline
// Masters an AHB-lite bus for both instruction fetch and load/store

`default_nettype none

module rv_core #(
	parameter rv_core_pkg::word_t RESET_VECTOR = 32'h0000_0000
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 hready_i,
	input  rv_core_pkg::word_t   hrdata_i,
	output rv_core_pkg::word_t   haddr_o,
	output rv_core_pkg::htrans_e htrans_o,
	output logic                 hwrite_o,
	output rv_core_pkg::hsize_e  hsize_o,
	output rv_core_pkg::word_t   hwdata_o
);
	import rv_core_pkg::*;

	mem_req_t  mem_req;
	redirect_t redirect;
	word_t     fetch_addr;
	word_t     fetch_pc;
	word_t     instr;
	logic      instr_valid;
	logic      stall;
	logic      hold;
	logic      fetch_issue;
	reg_idx_t  rs1;
	reg_idx_t  rs2;
	dx_ctrl_t  dx;
	word_t     rdata1;
	word_t     rdata2;
	xm_t       xm;
	wb_t       wb;

	rv_bus_ctrl i_bus_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.hready_i      (hready_i),
		.hrdata_i      (hrdata_i),
		.mem_req_i     (mem_req),
		.redirect_i    (redirect),
		.fetch_addr_i  (fetch_addr),
		.hold_i        (hold),
		.haddr_o       (haddr_o),
		.htrans_o      (htrans_o),
		.hwrite_o      (hwrite_o),
		.hsize_o       (hsize_o),
		.stall_o       (stall),
		.fetch_issue_o (fetch_issue),
		.instr_o       (instr),
		.instr_valid_o (instr_valid)
	);

	rv_pc_counter #(
		.RESET_VECTOR (RESET_VECTOR)
	) i_pc_counter (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall_i       (stall),
		.hold_i        (hold),
		.fetch_issue_i (fetch_issue),
		.redirect_i    (redirect),
		.fetch_addr_o  (fetch_addr),
		.fetch_pc_o    (fetch_pc)
	);

	rv_decode i_decode (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall_i       (stall),
		.hold_i        (hold),
		.redirect_i    (redirect),
		.instr_i       (instr),
		.instr_valid_i (instr_valid),
		.pc_i          (fetch_pc),
		.rs1_o         (rs1),
		.rs2_o         (rs2),
		.dx_o          (dx)
	);

	rv_regfile i_regfile (
		.clk      (clk),
		.rst_n    (rst_n),
		.stall_i  (stall),
		.hold_i   (hold),
		.rs1_i    (rs1),
		.rs2_i    (rs2),
		.wb_i     (wb),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2)
	);

	rv_execute i_execute (
		.clk        (clk),
		.rst_n      (rst_n),
		.stall_i    (stall),
		.dx_i       (dx),
		.rdata1_i   (rdata1),
		.rdata2_i   (rdata2),
		.wb_i       (wb),
		.mem_req_o  (mem_req),
		.redirect_o (redirect),
		.hold_o     (hold),
		.xm_o       (xm)
	);

	rv_mem_stage i_mem_stage (
		.clk      (clk),
		.rst_n    (rst_n),
		.stall_i  (stall),
		.xm_i     (xm),
		.hrdata_i (hrdata_i),
		.hwdata_o (hwdata_o),
		.wb_o     (wb)
	);

endmodule

`default_nettype wire

// ==== rv_core_sva.sv ====
// AHB-lite address phase assertions for the RV32I core
// Bound onto every rv_core instance

`default_nettype none

module rv_core_sva (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 hready_i,
	input rv_core_pkg::word_t   haddr_i,
	input rv_core_pkg::htrans_e htrans_i,
	input logic                 hwrite_i,
	input rv_core_pkg::hsize_e  hsize_i
);
	import rv_core_pkg::*;

	idle_in_reset: assert property (@(posedge clk) !rst_n |-> htrans_i == HTRANS_IDLE)
		else $error("htrans not IDLE during reset");

	// Address phase must hold while the slave inserts wait states
	stable_on_wait: assert property (@(posedge clk) disable iff (!rst_n)
		!hready_i |=> $stable(haddr_i) && $stable(htrans_i) && $stable(hwrite_i) &&
		$stable(hsize_i))
		else $error("address phase changed while hready low");

	aligned_store: assert property (@(posedge clk) disable iff (!rst_n)
		(htrans_i == HTRANS_NONSEQ && hwrite_i) |->
		((hsize_i == HSIZE_HALF) -> !haddr_i[0]) &&
		((hsize_i == HSIZE_WORD) -> haddr_i[1:0] == 2'b00))
		else $error("misaligned store address");

endmodule

bind rv_core rv_core_sva i_rv_core_sva (
	.clk      (clk),
	.rst_n    (rst_n),
	.hready_i (hready_i),
	.haddr_i  (haddr_o),
	.htrans_i (htrans_o),
	.hwrite_i (hwrite_o),
	.hsize_i  (hsize_o)
);

`default_nettype wire

// ==== tb_rv_core.sv ====
// Testbench for the RV32I core
// AHB-lite memory model, program table with signature stores,
// optional random wait states

`default_nettype none

module tb_rv_core;
	import rv_core_pkg::*;

	localparam word_t RESET_VECTOR = 32'h0000_0000;
	localparam int    NUM_PROGS    = 14;
	localparam int    PROG_LEN     = 10;
	localparam int    RESET_CYCLES = 5;
	localparam int    TIMEOUT      = NUM_PROGS * 2 * (PROG_LEN * 8 + RESET_CYCLES);
	localparam word_t SIG_ADDR     = 32'h0000_0200;
	localparam word_t TRAP_ADDR    = 32'h0000_0300;

	logic    clk;
	logic    rst_n;
	logic    hready;
	word_t   hrdata;
	word_t   haddr;
	htrans_e htrans;
	logic    hwrite;
	hsize_e  hsize;
	word_t   hwdata;

	// Program table
	word_t  prog_tab [NUM_PROGS][PROG_LEN];
	word_t  sig_tab  [NUM_PROGS];
	word_t  exp_tab  [NUM_PROGS];
	hsize_e size_tab [NUM_PROGS];
	word_t  mem_tab  [NUM_PROGS];
	word_t  calm_sig [NUM_PROGS];
	int     fill_n;
	int     fill_k;

	// Memory model state
	word_t  mem [0:255];
	logic   pend_valid = 1'b0;
	logic   pend_write;
	word_t  pend_addr;
	hsize_e pend_size;
	int     cur_prog;
	logic   wait_mode;
	int     sig_count;
	word_t  sig_data;
	hsize_e sig_size;
	int     trap_hits;
	logic   first_seen;
	word_t  first_addr;
	logic   first_write;
	hsize_e first_size;
	int     errors;
	int     cycles;

	rv_core #(
		.RESET_VECTOR (RESET_VECTOR)
	) i_rv_core (
		.clk      (clk),
		.rst_n    (rst_n),
		.hready_i (hready),
		.hrdata_i (hrdata),
		.haddr_o  (haddr),
		.htrans_o (htrans),
		.hwrite_o (hwrite),
		.hsize_o  (hsize),
		.hwdata_o (hwdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ============================================================
	// Instruction encoders
	// ============================================================
	function automatic word_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
		logic [2:0] f3, reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic word_t i_type(word_t imm, reg_idx_t rs1, logic [2:0] f3,
		reg_idx_t rd, logic [6:0] op);
		return {imm[11:0], rs1, f3, rd, op};
	endfunction

	function automatic word_t s_type(word_t imm, reg_idx_t rs2, reg_idx_t rs1,
		logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
	endfunction

	function automatic word_t b_type(word_t imm, reg_idx_t rs2, reg_idx_t rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic word_t u_type(word_t upper, reg_idx_t rd, logic [6:0] op);
		return {upper[19:0], rd, op};
	endfunction

	function automatic word_t j_type(word_t imm, reg_idx_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	function automatic word_t addi(reg_idx_t rd, reg_idx_t rs1, word_t imm);
		return i_type(imm, rs1, 3'b000, rd, 7'h13);
	endfunction

	// Unused slots spin on jal x0, 0
	task automatic start_prog(int n, word_t sig, word_t exp_data, hsize_e size,
		word_t exp_mem);
		for (int k = 0; k < PROG_LEN; k++) begin
			prog_tab[n][k] = j_type(32'd0, 5'd0);
		end
		sig_tab[n]  = sig;
		exp_tab[n]  = exp_data;
		size_tab[n] = size;
		mem_tab[n]  = exp_mem;
		fill_n = n;
		fill_k = 0;
	endtask

	task automatic emit(word_t w);
		prog_tab[fill_n][fill_k] = w;
		fill_k++;
	endtask

	// ============================================================
	// Program table with expected values from RV32I rules
	// ============================================================
	task automatic build_table();
		word_t a;
		word_t b;
		word_t d;
		word_t trap;
		trap = s_type(32'd256, 5'd0, 5'd10, 3'b010);
		// Dependent ALU chain
		a = 32'd1234;
		b = -32'sd5;
		start_prog(0, SIG_ADDR, ((a + b) - b) ^ b, HSIZE_WORD, ((a + b) - b) ^ b);
		emit(addi(5'd1, 5'd0, a));
		emit(addi(5'd2, 5'd0, b));
		emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
		emit(r_type(7'h20, 5'd2, 5'd3, 3'b000, 5'd4));
		emit(r_type(7'h00, 5'd2, 5'd4, 3'b100, 5'd5));
		emit(addi(5'd10, 5'd0, SIG_ADDR));
		emit(s_type(32'd0, 5'd5, 5'd10, 3'b010));
		// LUI and arithmetic shift
		a = 32'h8000_1234;
		b = word_t'($signed(a) >>> 3);
		start_prog(1, SIG_ADDR, a | b, HSIZE_WORD, a | b);
		emit(u_type(32'h80001, 5'd1, 7'h37));
		emit(addi(5'd1, 5'd1, 32'h234));
		emit(i_type(32'h403, 5'd1, 3'b101, 5'd2, 7'h13));
		emit(r_type(7'h00, 5'd1, 5'd2, 3'b110, 5'd3));
		emit(addi(5'd10, 5'd0, SIG_ADDR));
		emit(s_type(32'd0, 5'd3, 5'd10, 3'b010));
		// AUIPC at pc 4, signed and unsigned compares
		a = 32'd4 + 32'h0000_1000;
		b = 32'hFFFF_FFFF;
		d = a + word_t'($signed(b) < $signed(a)) + word_t'(b < a);
		start_prog(2, SIG_ADDR, d, HSIZE_WORD, d);
		emit(addi(5'd2, 5'd0, b));
		emit(u_type(32'h00001, 5'd1, 7'h17));
		emit(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd3));
		emit(r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd4));
		emit(r_type(7'h00, 5'd3, 5'd1, 3'b000, 5'd5));
		emit(r_type(7'h00, 5'd4, 5'd5, 3'b000, 5'd5));
		emit(addi(5'd10, 5'd0, SIG_ADDR));
		emit(s_type(32'd0, 5'd5, 5'd10, 3'b010));
		// Load then immediate use, and the same with a gap
		d = 32'h1234_8765;
		for (int n = 3; n <= 4; n++) begin
			start_prog(n, SIG_ADDR, d + 32'd7, HSIZE_WORD, d + 32'd7);
			emit(addi(5'd10, 5'd0, 32'h100));
			emit(addi(5'd11, 5'd0, SIG_ADDR));
			emit(i_type(32'd0, 5'd10, 3'b010, 5'd1, 7'h03));
			if (n == 4) begin
				emit(addi(5'd0, 5'd0, 32'd0));
				emit(addi(5'd0, 5'd0, 32'd0));
			end
			emit(addi(5'd2, 5'd1, 32'd7));
			emit(s_type(32'd0, 5'd2, 5'd11, 3'b010));
		end
		// Sub-word loads from 0x104
		d = 32'h80F0_F781;
		a = {{24{d[31]}}, d[31:24]} + {16'h0, d[31:16]};
		b = {{16{d[15]}}, d[15:0]} + {24'h0, d[15:8]};
		for (int n = 5; n <= 6; n++) begin
			start_prog(n, SIG_ADDR, (n == 5) ? a : b, HSIZE_WORD, (n == 5) ? a : b);
			emit(addi(5'd10, 5'd0, 32'h104));
			emit(i_type((n == 5) ? 32'd3 : 32'd0, 5'd10, (n == 5) ? 3'b000 : 3'b001,
				5'd1, 7'h03));
			emit(i_type((n == 5) ? 32'd2 : 32'd1, 5'd10, (n == 5) ? 3'b101 : 3'b100,
				5'd2, 7'h03));
			emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
			emit(addi(5'd11, 5'd0, SIG_ADDR));
			emit(s_type(32'd0, 5'd3, 5'd11, 3'b010));
		end
		// SB and SH into the preset word 0x11223344
		start_prog(7, SIG_ADDR + 32'd2, {4{8'h5A}}, HSIZE_BYTE, 32'h115A_3344);
		emit(addi(5'd1, 5'd0, 32'h5A));
		emit(addi(5'd10, 5'd0, SIG_ADDR));
		emit(s_type(32'd2, 5'd1, 5'd10, 3'b000));
		start_prog(8, SIG_ADDR + 32'd2, {2{16'hE123}}, HSIZE_HALF, 32'hE123_3344);
		emit(u_type(32'hABCDE, 5'd1, 7'h37));
		emit(addi(5'd1, 5'd1, 32'h123));
		emit(addi(5'd10, 5'd0, SIG_ADDR));
		emit(s_type(32'd2, 5'd1, 5'd10, 3'b001));
		// beq taken, bne not taken
		start_prog(9, SIG_ADDR, 32'd5, HSIZE_WORD, 32'd5);
		emit(addi(5'd1, 5'd0, 32'd5));
		emit(addi(5'd2, 5'd0, 32'd5));
		emit(addi(5'd10, 5'd0, SIG_ADDR));
		emit(b_type(32'd12, 5'd2, 5'd1, 3'b000));
		emit(trap);
		emit(trap);
		emit(b_type(32'd8, 5'd2, 5'd1, 3'b001));
		emit(s_type(32'd0, 5'd1, 5'd10, 3'b010));
		// blt taken, bltu not taken
		start_prog(10, SIG_ADDR, 32'd2 - (-32'sd3), HSIZE_WORD, 32'd5);
		emit(addi(5'd1, 5'd0, -32'sd3));
		emit(addi(5'd2, 5'd0, 32'd2));
		emit(addi(5'd10, 5'd0, SIG_ADDR));
		emit(b_type(32'd8, 5'd2, 5'd1, 3'b100));
		emit(trap);
		emit(b_type(32'd8, 5'd2, 5'd1, 3'b110));
		emit(r_type(7'h20, 5'd1, 5'd2, 3'b000, 5'd3));
		emit(s_type(32'd0, 5'd3, 5'd10, 3'b010));
		// bgeu and bge taken
		start_prog(11, SIG_ADDR, -32'sd3, HSIZE_WORD, -32'sd3);
		emit(addi(5'd1, 5'd0, -32'sd3));
		emit(addi(5'd2, 5'd0, 32'd2));
		emit(addi(5'd10, 5'd0, SIG_ADDR));
		emit(b_type(32'd8, 5'd2, 5'd1, 3'b111));
		emit(trap);
		emit(b_type(32'd8, 5'd1, 5'd2, 3'b101));
		emit(trap);
		emit(s_type(32'd0, 5'd1, 5'd10, 3'b010));
		// JAL at pc 4 links pc + 4
		start_prog(12, SIG_ADDR, 32'd4 + 32'd4, HSIZE_WORD, 32'd8);
		emit(addi(5'd10, 5'd0, SIG_ADDR));
		emit(j_type(32'd12, 5'd1));
		emit(trap);
		emit(trap);
		emit(s_type(32'd0, 5'd1, 5'd10, 3'b010));
		// JALR at pc 8 to (21 & ~1)
		start_prog(13, SIG_ADDR, 32'd8 + 32'd4, HSIZE_WORD, 32'd12);
		emit(addi(5'd10, 5'd0, SIG_ADDR));
		emit(addi(5'd5, 5'd0, 32'd21));
		emit(i_type(32'd0, 5'd5, 3'b000, 5'd1, 7'h67));
		emit(trap);
		emit(trap);
		emit(s_type(32'd0, 5'd1, 5'd10, 3'b010));
	endtask

	// ============================================================
	// AHB-lite memory model
	// ============================================================
	function automatic word_t init_word(int i);
		if (i < PROG_LEN) begin
			return prog_tab[cur_prog][i];
		end
		case (i)
			64:      return 32'h1234_8765;
			65:      return 32'h80F0_F781;
			128:     return 32'h1122_3344;
			default: return word_t'(i + 1) * 32'h9E37_79B9;
		endcase
	endfunction

	// Read data only during a data phase
	assign hrdata = pend_valid ? mem[pend_addr[9:2]] : '0;

	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 256; i++) begin
				mem[i] <= init_word(i);
			end
			pend_valid <= 1'b0;
			pend_write <= 1'b0;
			trap_hits  <= 0;
			first_seen <= 1'b0;
		end else if (hready) begin
			if (pend_valid && pend_write) begin
				case (pend_size)
					HSIZE_BYTE: mem[pend_addr[9:2]][{pend_addr[1:0], 3'b000} +: 8] <=
						hwdata[{pend_addr[1:0], 3'b000} +: 8];
					HSIZE_HALF: mem[pend_addr[9:2]][{pend_addr[1], 4'b0000} +: 16] <=
						hwdata[{pend_addr[1], 4'b0000} +: 16];
					default:    mem[pend_addr[9:2]] <= hwdata;
				endcase
				if (pend_addr == sig_tab[cur_prog]) begin
					sig_data  <= hwdata;
					sig_size  <= pend_size;
					sig_count <= sig_count + 1;
				end
				if (pend_addr == TRAP_ADDR) begin
					trap_hits <= trap_hits + 1;
				end
			end
			if (htrans == HTRANS_NONSEQ && !first_seen) begin
				first_seen  <= 1'b1;
				first_addr  <= haddr;
				first_write <= hwrite;
				first_size  <= hsize;
			end
			pend_valid <= htrans == HTRANS_NONSEQ;
			pend_write <= hwrite && htrans == HTRANS_NONSEQ;
			pend_addr  <= haddr;
			pend_size  <= hsize;
		end
	end

	// Wait states on falling edges
	always @(negedge clk) begin
		if (wait_mode && rst_n) begin
			hready <= ($urandom % 4) != 0;
		end else begin
			hready <= 1'b1;
		end
	end

	// ============================================================
	// Checks
	// ============================================================
	task automatic check_word(string name, word_t got, word_t exp_val);
		if (got !== exp_val) begin
			$display("Error at %0t: %s is %08h, expected %08h", $time, name, got, exp_val);
			errors++;
		end
	endtask

	task automatic check_size(string name, hsize_e got, hsize_e exp_val);
		if (got !== exp_val) begin
			$display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp_val);
			errors++;
		end
	endtask

	task automatic run_program(int n, logic waits);
		int start;
		@(negedge clk);
		rst_n     <= 1'b0;
		cur_prog  <= n;
		wait_mode <= waits;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n <= 1'b1;
		start = sig_count;
		do @(negedge clk); while (sig_count == start);
		check_word("first haddr_o", first_addr, RESET_VECTOR);
		check_word("first hwrite_o", {31'b0, first_write}, 32'd0);
		check_size("first hsize_o", first_size, HSIZE_WORD);
		check_word("hwdata_o", sig_data, exp_tab[n]);
		check_size("hsize_o", sig_size, size_tab[n]);
		check_word("memory word", mem[sig_tab[n][9:2]], mem_tab[n]);
		if (trap_hits != 0) begin
			$display("Program %0d stored from a path that a jump or branch skips", n);
			errors++;
		end
		if (!waits) begin
			calm_sig[n] = sig_data;
		end else begin
			check_word("hwdata_o with wait states", sig_data, calm_sig[n]);
		end
	endtask

	// Watchdog
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, a signature store never arrived", cycles);
		$display("Errors: %0d", errors + 1);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		rst_n     <= 1'b0;
		hready    <= 1'b1;
		wait_mode <= 1'b0;
		cur_prog  <= 0;
		sig_count = 0;
		errors    = 0;
		void'($urandom(52));
		build_table();
		for (int pass = 0; pass < 2; pass++) begin
			for (int n = 0; n < NUM_PROGS; n++) begin
				run_program(n, pass == 1);
			end
		end
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
rv_core_pkg.sv
rv_bus_ctrl.sv
rv_pc_counter.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_mem_stage.sv
rv_core.sv
rv_core_sva.sv
tb_rv_core.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_rv_core
FILELIST   := list.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0 --Mdir $(BUILD_DIR)
PASS_TEXT  := Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
